//--- video_crop.f
+incdir+.
video_crop_pkg.sv
crop_keys.sv
raster_counter.sv
blank_gen.sv
screen_info.sv
video_crop.sv
video_crop_assert.sv
tb_clock.sv
tb_video_crop.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the video crop testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_video_crop \
	-f video_crop.f -o tb_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "All checks passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_video_crop.sv
/*
  Testbench for the video crop core.
  Generates a 400 x 60 raster, drives crop keys and presets,
  predicts offsets and de counts from the crop rules and checks
  the frame snapshot, the de pattern and both blank outputs of
  every checked frame.
*/
`timescale 1ns/1ns
`include "video_crop_consts.svh"

module tb_video_crop;
	import video_crop_pkg::*;

	typedef logic [7:0] key_q_t[$];

	logic clk_28, arst_n;
	logic hs, vs, hblank, vblank;
	logic [1:0] res;
	kbd_event_t kbd;
	logic preset_set;
	crop_t preset_crop;
	logic de, hbl_out, vbl_out;
	screen_info_t info;
	logic [6:0] info_seq;

	int hb_s, hb_e, vb_s, vb_e;          // programmed blank windows
	crop_t cur_crop;                     // expected live offsets
	int exp_w, exp_h;
	int run_len, de_lines;
	int hbl_run, vbl_low;                // blank output counters
	logic de_prev;
	logic hbl_prev;
	bit meas_on;
	logic [6:0] seq_base;

	tb_clock u_clock (.clk_28(clk_28), .arst_n(arst_n));

	video_crop dut (
		.clk_28(clk_28), .arst_n(arst_n), .hs(hs), .vs(vs),
		.hblank(hblank), .vblank(vblank), .res(res), .kbd(kbd),
		.preset_set(preset_set), .preset_crop(preset_crop),
		.de(de), .hbl_out(hbl_out), .vbl_out(vbl_out),
		.info(info), .info_seq(info_seq)
	);

	////////////////////
	// reporting
	////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_info(input string name, input screen_info_t exp, input screen_info_t act);
		if (exp !== act)
			stop_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_seq(input string name, input logic [6:0] exp, input logic [6:0] act);
		if (exp !== act)
			stop_run($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (exp !== act)
			stop_run($sformatf("Mismatch %s expected %0d actual %0d", name, exp, act));
	endtask

	////////////////////
	// reference model
	////////////////////

	// offsets after a key list, alt released at start
	function automatic crop_t ref_crop(input crop_t start, input key_q_t keys);
		crop_t c;
		bit alt;
		c = start;
		alt = 1'b0;
		foreach (keys[i]) begin
			case (keys[i])
				`KEY_BKSP: c = '0;
				`KEY_UP: begin
					if (alt) c.bottom = c.bottom + `VSTEP;
					else     c.top    = c.top + `VSTEP;
				end
				`KEY_DOWN: begin
					if (alt) c.bottom = c.bottom - `VSTEP;
					else     c.top    = c.top - `VSTEP;
				end
				`KEY_LEFT: begin
					if (alt) c.right = c.right + `HSTEP;
					else     c.left  = c.left + `HSTEP;
				end
				`KEY_RIGHT: begin
					if (alt) c.right = c.right - `HSTEP;
					else     c.left  = c.left - `HSTEP;
				end
				`KEY_ALT_L, `KEY_ALT_R: alt = 1'b1;
				`KEY_ALT_L_UP, `KEY_ALT_R_UP: alt = 1'b0;
				default: ;
			endcase
		end
		return c;
	endfunction

	////////////////////
	// de monitor
	////////////////////

	always @(posedge clk_28) begin
		if (meas_on) begin
			if (de) run_len = run_len + 1;
			if (de && !de_prev) de_lines = de_lines + 1;   // new de line
			if (!de && de_prev) begin
				check_count("de width per line", exp_w, run_len);
				run_len = 0;
			end
			if (!hbl_out) hbl_run = hbl_run + 1;
			if (hbl_out && !hbl_prev) begin                // end of the open part of a line
				if (vs) check_count("hbl_out width per line", exp_w, hbl_run);   // skip sync lines
				hbl_run = 0;
			end
			if (!vbl_out) vbl_low = vbl_low + 1;
		end
		de_prev  = de;
		hbl_prev = hbl_out;
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic run_frame();
		for (int l = 0; l < 60; l++) begin
			for (int p = 0; p < 400; p++) begin
				@(posedge clk_28);
				hs     <= (p >= 16);                 // 16 pixel sync
				vs     <= (l >= 2);                  // 2 line sync
				hblank <= !(p >= hb_s && p < hb_e);
				vblank <= !(l >= vb_s && l < vb_e);
			end
		end
		repeat (4) @(posedge clk_28);
	endtask

	task automatic press_key(input logic [7:0] code);
		@(posedge clk_28);
		kbd.stb  <= 1'b1;
		kbd.typ  <= `KMS_TYPE_KEY;
		kbd.data <= code;
		@(posedge clk_28);
		kbd.stb  <= 1'b0;
	endtask

	task automatic load_preset(input crop_t p, input bit with_key);
		@(posedge clk_28);
		preset_set  <= 1'b1;
		preset_crop <= p;
		if (with_key) begin
			kbd.stb  <= 1'b1;                      // same cycle, preset wins
			kbd.typ  <= `KMS_TYPE_KEY;
			kbd.data <= `KEY_UP;
		end
		@(posedge clk_28);
		preset_set <= 1'b0;
		kbd.stb    <= 1'b0;
		cur_crop    = p;
	endtask

	// random walk that never takes an offset below zero
	task automatic random_keys(input int n, output key_q_t keys);
		int cnt[4];
		int r, tgt;
		bit alt;
		logic [7:0] k;
		keys = {};
		cnt = '{0, 0, 0, 0};
		alt = 1'b0;
		for (int i = 0; i < n; i++) begin
			r = $urandom % 5;
			if (r == 4) begin
				k = alt ? `KEY_ALT_L_UP : (($urandom % 2) ? `KEY_ALT_R : `KEY_ALT_L);
				alt = !alt;
			end else begin
				tgt = (r < 2) ? (alt ? 1 : 0) : (alt ? 3 : 2);   // top bottom left right
				if ((r == 1 || r == 3) && cnt[tgt] == 0) r = r - 1;
				k = (r == 0) ? `KEY_UP : (r == 1) ? `KEY_DOWN : (r == 2) ? `KEY_LEFT : `KEY_RIGHT;
				cnt[tgt] = cnt[tgt] + ((r == 0 || r == 2) ? 1 : -1);
			end
			keys.push_back(k);
		end
		if (alt) keys.push_back(`KEY_ALT_R_UP);
		foreach (keys[i]) press_key(keys[i]);
	endtask

	task automatic frame_and_check(input string name);
		screen_info_t exp;
		exp_w = (hb_e - hb_s) - int'(cur_crop.left) - int'(cur_crop.right);
		exp_h = (vb_e - vb_s) - int'(cur_crop.top) - int'(cur_crop.bottom);
		run_len  = 0;
		de_lines = 0;
		hbl_run  = 0;
		vbl_low  = 0;
		meas_on  = 1'b1;
		run_frame();
		meas_on  = 1'b0;
		exp.crop  = cur_crop;
		exp.hsize = `CNT_W'(hb_e - hb_s);
		exp.vsize = `CNT_W'(vb_e - vb_s);
		exp.res   = res;
		check_info({name, " info"}, exp, info);
		check_count({name, " de lines"}, exp_h, de_lines);
		check_count({name, " vbl_out low cycles"}, exp_h * 400, vbl_low);   // whole lines open
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		key_q_t keys;
		int cyc;
		hs = 1'b1;
		vs = 1'b1;
		hblank = 1'b1;
		vblank = 1'b1;
		res = 2'd1;
		kbd = '0;
		preset_set = 1'b0;
		preset_crop = '0;
		cur_crop = '0;
		meas_on = 1'b0;
		de_prev = 1'b0;
		hbl_prev = 1'b1;
		void'($urandom(32'h1125));

		cyc = 0;
		while (arst_n !== 1'b1) begin              // reset release, bounded
			@(posedge clk_28);
			cyc++;
			if (cyc > 100) stop_run("reset was never released");
		end
		@(posedge clk_28);
		check_count("de after reset", 0, int'(de));
		check_seq("seq after reset", 7'd0, info_seq);

		hb_s = 24 + $urandom % 40;
		hb_e = 300 + $urandom % 80;
		vb_s = 4 + $urandom % 6;
		vb_e = 45 + $urandom % 10;
		run_frame();                               // vsize known after first frame
		run_frame();
		frame_and_check("zero crop");

		seq_base = info_seq;
		random_keys(24, keys);
		cur_crop = ref_crop(cur_crop, keys);
		frame_and_check("random keys");
		check_seq("seq after keys", seq_base, info_seq);

		press_key(`KEY_BKSP);
		cur_crop = '0;
		frame_and_check("backspace");

		load_preset('{top: `CNT_W'($urandom % 10), bottom: `CNT_W'($urandom % 10),
		              left: `CNT_W'($urandom % 40), right: `CNT_W'($urandom % 40)}, 1'b0);
		frame_and_check("preset");
		load_preset('{top: `CNT_W'($urandom % 10), bottom: `CNT_W'($urandom % 10),
		              left: `CNT_W'($urandom % 40), right: `CNT_W'($urandom % 40)}, 1'b1);
		frame_and_check("preset with key");

		seq_base = info_seq;
		frame_and_check("same geometry");
		check_seq("seq steady", seq_base, info_seq);
		hb_e = hb_e - 8;                           // narrower active width
		frame_and_check("new width");
		check_seq("seq after width", seq_base + 7'd1, info_seq);
		frame_and_check("width steady");
		check_seq("seq width steady", seq_base + 7'd1, info_seq);
		res <= 2'd2;
		frame_and_check("new res");
		check_seq("seq after res", seq_base + 7'd2, info_seq);

		$display("All checks passed");
		$finish;
	end

endmodule

//--- tb_clock.sv
/*
  Clock and reset source for the crop core testbench.
  100 ns period, reset held low for the first 16 cycles.
*/
`timescale 1ns/1ns

module tb_clock (
	output logic clk_28,
	output logic arst_n
);

	initial begin
		clk_28 = 1'b0;
		forever #50 clk_28 = ~clk_28;              // 100 ns period
	end

	initial begin
		arst_n = 1'b0;
		repeat (16) @(posedge clk_28);
		arst_n <= 1'b1;                            // release on an edge
	end

endmodule

//--- video_crop_assert.sv
/*
  Concurrent checks on the crop core outputs, bound to the
  top level. de must stay low in sync and in blank, and
  info_seq may only move right after a frame snapshot that
  changed the size or the mode.
*/
`timescale 1ns/1ns

module video_crop_assert (
	input logic                         clk_28,
	input logic                         arst_n,
	input logic                         hs,
	input logic                         hblank,
	input logic                         de,
	input logic                         hbl_out,
	input logic                         frame_tick,
	input video_crop_pkg::screen_info_t info,
	input logic [6:0]                   info_seq
);

	// no pixels during hsync
	de_in_sync: assert property (@(posedge clk_28) disable iff (!arst_n)
		!hs |-> !de)
		else $error("de high while hs low");

	// source blank reaches de two clocks later
	de_in_blank: assert property (@(posedge clk_28) disable iff (!arst_n)
		(hbl_out || $past(hblank, 2)) |-> !de)
		else $error("de high while blanking");

	// seq steps only on a snapshot with new size or mode
	seq_on_tick: assert property (@(posedge clk_28) disable iff (!arst_n)
		(info_seq != $past(info_seq)) |-> $past(frame_tick) &&
			((info.res != $past(info.res)) || (info.hsize != $past(info.hsize)) ||
			 (info.vsize != $past(info.vsize))))
		else $error("info_seq changed without a new snapshot size or mode");

endmodule

bind video_crop video_crop_assert u_assert (
	.clk_28     (clk_28),
	.arst_n     (arst_n),
	.hs         (hs),
	.hblank     (hblank),
	.de         (de),
	.hbl_out    (hbl_out),
	.frame_tick (frame_tick),
	.info       (info),
	.info_seq   (info_seq)
);

//--- video_crop.sv
/*
  Video crop core, top level.
  Measures the incoming raster, keeps keyboard driven crop
  offsets and produces narrowed blanking and data enable,
  plus a frame snapshot for the host. All on clk_28.
*/
`timescale 1ns/1ns
`include "video_crop_consts.svh"

module video_crop (
	input  logic                         clk_28,
	input  logic                         arst_n,
	input  logic                         hs,            // active low
	input  logic                         vs,            // active low
	input  logic                         hblank,
	input  logic                         vblank,
	input  logic [1:0]                   res,
	input  video_crop_pkg::kbd_event_t   kbd,
	input  logic                         preset_set,
	input  video_crop_pkg::crop_t        preset_crop,
	output logic                         de,
	output logic                         hbl_out,
	output logic                         vbl_out,
	output video_crop_pkg::screen_info_t info,
	output logic [6:0]                   info_seq
);
	import video_crop_pkg::*;

	crop_t             crop;         // live offsets
	geom_t             geom;         // measured raster
	logic [`CNT_W-1:0] hcnt;
	logic [`CNT_W-1:0] vcnt;
	logic              line_tick;
	logic              frame_tick;

	crop_keys u_keys (
		.clk_28      (clk_28),
		.arst_n      (arst_n),
		.kbd         (kbd),
		.preset_set  (preset_set),
		.preset_crop (preset_crop),
		.crop        (crop)
	);

	raster_counter u_raster (
		.clk_28     (clk_28),
		.arst_n     (arst_n),
		.hs         (hs),
		.vs         (vs),
		.hblank     (hblank),
		.vblank     (vblank),
		.hcnt       (hcnt),
		.vcnt       (vcnt),
		.line_tick  (line_tick),
		.frame_tick (frame_tick),
		.geom       (geom)
	);

	blank_gen u_blank (
		.clk_28    (clk_28),
		.arst_n    (arst_n),
		.hs        (hs),
		.vs        (vs),
		.hcnt      (hcnt),
		.vcnt      (vcnt),
		.line_tick (line_tick),
		.geom      (geom),
		.crop      (crop),
		.de        (de),
		.hbl_out   (hbl_out),
		.vbl_out   (vbl_out)
	);

	screen_info u_info (
		.clk_28     (clk_28),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.geom       (geom),
		.crop       (crop),
		.res        (res),
		.info       (info),
		.info_seq   (info_seq)
	);

endmodule

//--- screen_info.sv
/*
  Per-frame snapshot of geometry, offsets and mode.
  Taken on frame_tick; info_seq steps whenever the mode or
  the measured size differs from the previous snapshot, so a
  host can poll it to spot resolution changes.
*/
`timescale 1ns/1ns

module screen_info (
	input  logic                         clk_28,
	input  logic                         arst_n,
	input  logic                         frame_tick,
	input  video_crop_pkg::geom_t        geom,
	input  video_crop_pkg::crop_t        crop,
	input  logic [1:0]                   res,
	output video_crop_pkg::screen_info_t info,
	output logic [6:0]                   info_seq
);
	import video_crop_pkg::*;

	screen_info_t snap;    // what this frame would store
	logic         changed;

	always_comb begin
		snap.crop  = crop;
		snap.hsize = geom.hsize;
		snap.vsize = geom.vsize;
		snap.res   = res;
	end

	// offsets alone do not count as a change
	assign changed = (snap.res != info.res) || (snap.hsize != info.hsize) ||
	                 (snap.vsize != info.vsize);

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			info     <= '0;
			info_seq <= '0;
		end else if (frame_tick) begin
			info <= snap;
			if (changed) info_seq <= info_seq + 1'b1;   // wraps at 128
		end
	end

endmodule

//--- blank_gen.sv
/*
  Cropped blanking and data enable.
  The horizontal window is checked every pixel, the vertical
  one once per line on line_tick. Forced blanking near both
  syncs hides edge garbage. Outputs are registered together
  so de never disagrees with hbl_out or vbl_out.
*/
`timescale 1ns/1ns
`include "video_crop_consts.svh"

module blank_gen (
	input  logic                  clk_28,
	input  logic                  arst_n,
	input  logic                  hs,          // active low
	input  logic                  vs,          // active low
	input  logic [`CNT_W-1:0]     hcnt,
	input  logic [`CNT_W-1:0]     vcnt,
	input  logic                  line_tick,
	input  video_crop_pkg::geom_t geom,
	input  video_crop_pkg::crop_t crop,
	output logic                  de,
	output logic                  hbl_out,
	output logic                  vbl_out
);

	localparam logic [`CNT_W-1:0] HFORCE_C = `CNT_W'(`HFORCE);
	localparam logic [`CNT_W-1:0] VFORCE_C = `CNT_W'(`VFORCE);

	logic chbl, fhbl;     // cropped / forced horizontal
	logic cvbl, fvbl;     // cropped / forced vertical
	logic hbl, vbl;

	assign hbl = chbl | fhbl | ~hs;
	assign vbl = cvbl | fvbl | ~vs;

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			chbl    <= 1'b1;
			fhbl    <= 1'b1;
			cvbl    <= 1'b1;
			fvbl    <= 1'b1;
			de      <= 1'b0;
			hbl_out <= 1'b1;
			vbl_out <= 1'b1;
		end else begin
			// open at hend+left, close at hsta-right
			chbl <= !((hcnt >= geom.hend + crop.left) && (hcnt < geom.hsta - crop.right));
			fhbl <= (hcnt < HFORCE_C) || (hcnt >= geom.hmax - HFORCE_C);

			if (line_tick) begin                       // once per line
				cvbl <= !((vcnt >= geom.vend + crop.top) && (vcnt < geom.vsta - crop.bottom));
				fvbl <= (vcnt == '0) || (vcnt >= geom.vmax - VFORCE_C);
			end

			de      <= ~(hbl | vbl);                   // one cycle behind the blanks
			hbl_out <= hbl;
			vbl_out <= vbl;
		end
	end

endmodule

//--- raster_counter.sv
/*
  Pixel and line counters for the incoming raster.
  Records where the blanks start and end and the line/frame
  totals, and derives the active width and height from them.
  line_tick and frame_tick mark the hs fall and the end of the
  combined vertical blank, one cycle after the input edge.
*/
`timescale 1ns/1ns
`include "video_crop_consts.svh"

module raster_counter (
	input  logic                  clk_28,
	input  logic                  arst_n,
	input  logic                  hs,          // active low
	input  logic                  vs,          // active low
	input  logic                  hblank,      // high while blanking
	input  logic                  vblank,      // high while blanking
	output logic [`CNT_W-1:0]     hcnt,
	output logic [`CNT_W-1:0]     vcnt,
	output logic                  line_tick,
	output logic                  frame_tick,
	output video_crop_pkg::geom_t geom
);

	logic vbl_c;                            // vblank or vsync
	logic old_hs, old_vs, old_hblank, old_vbl;
	logic hs_fall, vs_fall;
	logic hbl_rise, hbl_fall;
	logic vbl_rise, vbl_fall;

	assign vbl_c    = vblank | ~vs;

	assign hs_fall  = old_hs & ~hs;
	assign vs_fall  = old_vs & ~vs;
	assign hbl_fall = old_hblank & ~hblank;  // active area starts
	assign hbl_rise = ~old_hblank & hblank;  // active area ends
	assign vbl_fall = old_vbl & ~vbl_c;
	assign vbl_rise = ~old_vbl & vbl_c;

	////////////////////
	// edges and counters
	////////////////////

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			old_hs     <= 1'b1;
			old_vs     <= 1'b1;
			old_hblank <= 1'b1;
			old_vbl    <= 1'b1;
			hcnt       <= '0;
			vcnt       <= '0;
			line_tick  <= 1'b0;
			frame_tick <= 1'b0;
		end else begin
			old_hs     <= hs;
			old_vs     <= vs;
			old_hblank <= hblank;
			old_vbl    <= vbl_c;

			hcnt <= hs ? hcnt + 1'b1 : '0;            // held at zero during hs

			if (hs_fall) vcnt <= vcnt + 1'b1;         // one per line
			if (!vs)     vcnt <= '0;

			line_tick  <= hs_fall;                    // vcnt already stepped
			frame_tick <= vbl_fall;
		end
	end

	////////////////////
	// geometry capture
	////////////////////

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			geom <= '0;
		end else begin
			if (hbl_fall) geom.hend <= hcnt;
			if (hbl_rise) begin
				geom.hsta  <= hcnt;
				geom.hsize <= hcnt - geom.hend;           // width of this line
			end
			if (hs_fall) geom.hmax <= hcnt;           // line total

			if (vbl_fall) geom.vend <= vcnt;
			if (vbl_rise) begin
				geom.vsta  <= vcnt;
				geom.vsize <= vcnt - geom.vend;           // height of this frame
			end
			if (vs_fall) geom.vmax <= vcnt;           // frame total
		end
	end

endmodule

//--- crop_keys.sv
/*
  Crop offset register with keyboard control.
  Up/down move the top offset, left/right the left offset;
  with alt held they move bottom and right instead.
  Backspace clears everything, preset_set loads all four
  offsets at once and wins over a key on the same cycle.
*/
`timescale 1ns/1ns
`include "video_crop_consts.svh"

module crop_keys (
	input  logic                       clk_28,
	input  logic                       arst_n,
	input  video_crop_pkg::kbd_event_t kbd,
	input  logic                       preset_set,   // one cycle load
	input  video_crop_pkg::crop_t      preset_crop,
	output video_crop_pkg::crop_t      crop
);
	import video_crop_pkg::*;

	localparam logic [`CNT_W-1:0] HSTEP_C = `CNT_W'(`HSTEP);
	localparam logic [`CNT_W-1:0] VSTEP_C = `CNT_W'(`VSTEP);

	typedef enum logic {
		ALT_UP,                                    // alt released
		ALT_HELD                                   // alt down, keys move bottom/right
	} alt_state_t;

	alt_state_t alt_q, alt_d;
	crop_t      crop_d;
	logic       adj_stb;                           // strobe of an adjust key
	logic       old_stb;
	logic       key_hit;                           // rising edge only

	assign adj_stb = kbd.stb && (kbd.typ == `KMS_TYPE_KEY);
	assign key_hit = adj_stb && !old_stb;

	////////////////////
	// next offsets
	////////////////////

	always_comb begin
		crop_d = crop;
		alt_d  = alt_q;
		if (key_hit) begin
			case (kbd.data)
				`KEY_BKSP: crop_d = '0;                                   // clear all four
				`KEY_UP: begin
					if (alt_q == ALT_HELD) crop_d.bottom = crop.bottom + VSTEP_C;
					else                   crop_d.top    = crop.top + VSTEP_C;
				end
				`KEY_DOWN: begin
					if (alt_q == ALT_HELD) crop_d.bottom = crop.bottom - VSTEP_C;
					else                   crop_d.top    = crop.top - VSTEP_C;
				end
				`KEY_LEFT: begin
					if (alt_q == ALT_HELD) crop_d.right = crop.right + HSTEP_C;
					else                   crop_d.left  = crop.left + HSTEP_C;
				end
				`KEY_RIGHT: begin
					if (alt_q == ALT_HELD) crop_d.right = crop.right - HSTEP_C;
					else                   crop_d.left  = crop.left - HSTEP_C;
				end
				`KEY_ALT_L, `KEY_ALT_R:       alt_d = ALT_HELD;
				`KEY_ALT_L_UP, `KEY_ALT_R_UP: alt_d = ALT_UP;
				default: ;                                                 // other keys ignored
			endcase
		end
		if (preset_set) crop_d = preset_crop;                             // preset has priority
	end

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge clk_28 or negedge arst_n) begin
		if (!arst_n) begin
			old_stb <= 1'b0;
			alt_q   <= ALT_UP;
			crop    <= '0;
		end else begin
			old_stb <= adj_stb;   // edge detector input
			alt_q   <= alt_d;
			crop    <= crop_d;    // wraps mod 4096
		end
	end

endmodule

//--- video_crop_pkg.sv
/*
  Packed types shared by the crop core and its testbench.
  Keyboard event, crop offsets, measured geometry and the
  per-frame screen info snapshot.
*/
`include "video_crop_consts.svh"

package video_crop_pkg;

	// one keyboard/mouse event from the host
	typedef struct packed {
		logic       stb;               // level strobe, edge is the event
		logic [1:0] typ;               // 3 = adjust key
		logic [7:0] data;              // key code
	} kbd_event_t;

	// crop offsets, all in counter units
	typedef struct packed {
		logic [`CNT_W-1:0] top;        // lines cut at the top
		logic [`CNT_W-1:0] bottom;     // lines cut at the bottom
		logic [`CNT_W-1:0] left;       // pixels cut on the left
		logic [`CNT_W-1:0] right;      // pixels cut on the right
	} crop_t;

	// measured raster geometry
	typedef struct packed {
		logic [`CNT_W-1:0] hsize;      // active width
		logic [`CNT_W-1:0] vsize;      // active height
		logic [`CNT_W-1:0] hend;       // hblank end position
		logic [`CNT_W-1:0] hsta;       // hblank start position
		logic [`CNT_W-1:0] hmax;       // hcnt at hs fall
		logic [`CNT_W-1:0] vend;       // vblank end line
		logic [`CNT_W-1:0] vsta;       // vblank start line
		logic [`CNT_W-1:0] vmax;       // vcnt at vs fall
	} geom_t;

	// snapshot taken at each vblank end
	typedef struct packed {
		crop_t             crop;
		logic [`CNT_W-1:0] hsize;
		logic [`CNT_W-1:0] vsize;
		logic [1:0]        res;        // resolution mode
	} screen_info_t;

endpackage

//--- video_crop_consts.svh
/*
  Shared constants for the video crop core.
  Counter width, keyboard codes for the crop adjust keys,
  step sizes and forced blank margins.
  Include where a macro is needed; the guard allows repeats.
*/
`ifndef VIDEO_CROP_CONSTS_SVH
`define VIDEO_CROP_CONSTS_SVH

////////////////////
// geometry
////////////////////

`define CNT_W         12      // pixel/line counters and offsets

////////////////////
// keyboard events
////////////////////

`define KMS_TYPE_KEY  2'd3    // event type for adjust keys

`define KEY_BKSP      8'h41   // clear all offsets
`define KEY_UP        8'h4c   // top/bottom plus one line
`define KEY_DOWN      8'h4d   // top/bottom minus one line
`define KEY_RIGHT     8'h4e   // left/right minus step
`define KEY_LEFT      8'h4f   // left/right plus step
`define KEY_ALT_L     8'h64   // alt press, left
`define KEY_ALT_R     8'h65   // alt press, right
`define KEY_ALT_L_UP  8'he4   // alt release, left
`define KEY_ALT_R_UP  8'he5   // alt release, right

////////////////////
// steps and margins
////////////////////

`define HSTEP         4       // pixels per left/right key
`define VSTEP         1       // lines per up/down key

`define HFORCE        8       // pixels blanked at both hs ends
`define VFORCE        3       // lines blanked before vs

`endif
